/* compile.f */
logic/ks10MemPkg.sv
logic/memReqIf.sv
logic/busDecode.sv
logic/memStatus.sv
logic/ssramCtrl.sv
logic/memCtrl.sv
verification/clockGen.sv
verification/ssramModel.sv
verification/memCtrlTb.sv

/* Makefile */
TOP = memCtrlTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q '^Finished with no errors$$'

lint:
	verilator --lint-only --timing -f compile.f --top-module memCtrl

clean:
	rm -rf obj_dir

/* verification/memCtrlTb.sv */
////////////////////
// Memory controller testbench
// Four-phase bus master, reference memory, MSR prediction
////////////////////

`timescale 1ns/1ns
`default_nettype none

module memCtrlTb;
   import ks10MemPkg::*;

   localparam int memWords    = 65536;
   localparam int addrWidth   = 20;
   localparam int readLatency = 2;
   localparam int ackLimit    = 40;              // Cycles to wait for busAck
   localparam int rejectHold  = 20;              // Master gives up after this
   localparam int cycleLimit  = 100 * 20 * 3;    // 100 transfers, 20 cycles, margin

   logic                 cpuClk;
   logic                 rst;
   logic                 busReq;
   logic                 busAck;
   wordT                 busAddr;
   wordT                 busDataIn;
   wordT                 busDataOut;
   logic [addrWidth-1:0] ssramAddr;
   wordT                 ssramDataOut;
   wordT                 ssramDataIn;
   logic                 ssramWeN;
   logic                 ssramCeN;
   logic                 ssramOe;

   wordT                       refMem [int];  // Last word written per address
   int                         addrList [32];
   wordT                       expData;
   logic                       chkMem;        // Memory data due on busAck
   logic                       chkMsr;        // MSR value due on busAck
   logic                       expectReject;  // No busAck allowed
   logic                       nxmModel;
   logic [msrScratchWidth-1:0] scratchModel;
   wordT                       msrModel;
   string                      testName;
   int                         errors = 0;
   int                         testNum = 0;
   int                         testErrStart = 0;
   int                         failedTests = 0;
   int                         cycles = 0;
   integer                     seed = 96;

   clockGen clk_i (.cpuClk(cpuClk), .rst(rst));

   memCtrl #(
      .memWords       (memWords),
      .ssramAddrWidth (addrWidth),
      .readLatency    (readLatency)
   ) dut_i (
      .cpuClk(cpuClk), .rst(rst), .busReq(busReq), .busAck(busAck),
      .busAddr(busAddr), .busDataIn(busDataIn), .busDataOut(busDataOut),
      .ssramAddr(ssramAddr), .ssramDataOut(ssramDataOut), .ssramDataIn(ssramDataIn),
      .ssramWeN(ssramWeN), .ssramCeN(ssramCeN), .ssramOe(ssramOe)
   );

   ssramModel #(.addrWidth(addrWidth), .words(memWords), .latency(readLatency)) sram_i (
      .clk(cpuClk), .addr(ssramAddr), .dataIn(ssramDataOut), .dataOut(ssramDataIn),
      .weN(ssramWeN), .ceN(ssramCeN), .oe(ssramOe)
   );

   ////////////////////
   // Checkers

   readDataOk: assert property (@(posedge cpuClk) disable iff (rst)
      busAck && chkMem |-> busDataOut == expData)
      else
      begin
         errors++;
         $display("FAILED busDataOut %h expected %h", $sampled(busDataOut), $sampled(expData));
      end

   msrValueOk: assert property (@(posedge cpuClk) disable iff (rst)
      busAck && chkMsr |-> busDataOut == msrModel)
      else
      begin
         errors++;
         $display("FAILED MSR busDataOut %h expected %h", $sampled(busDataOut),
                  $sampled(msrModel));
      end

   noAckOnReject: assert property (@(posedge cpuClk) disable iff (rst)
      expectReject |-> !busAck)
      else
      begin
         errors++;
         $display("Request that should be ignored was acknowledged");
      end

   // Run limit
   always @(posedge cpuClk)
   begin
      cycles++;
      if (cycles >= cycleLimit)
      begin
         $display("Run stopped after %0d cycles", cycles);
         $display("Finished with errors");
         $finish;
      end
   end

   ////////////////////
   // Bus words and helpers

   function automatic wordT memWord(input logic rd, input logic wt, input logic wr, input int a);
      wordT w;
      w = '0;
      w[busReadBit]         = rd;
      w[busWrTestBit]       = wt;
      w[busWriteBit]        = wr;
      w[busPhysBit]         = 1'b1;
      w[busMemAddrMsb:0]    = a[busMemAddrMsb:0];
      return w;
   endfunction

   function automatic wordT ioWord(input logic rd, input logic wr, input logic [3:0] dev,
                                   input logic [17:0] ioAddr);
      wordT w;
      w = '0;
      w[busReadBit]              = rd;
      w[busWriteBit]             = wr;
      w[busPhysBit]              = 1'b1;
      w[busIoBit]                = 1'b1;
      w[busDevMsb:busDevLsb]     = dev;
      w[busIoAddrMsb:0]          = ioAddr;
      return w;
   endfunction

   function automatic wordT randWord();
      return wordT'({$random(seed), $random(seed)});
   endfunction

   // MSR as the register rules give it
   task automatic updateMsr();
      msrModel                        = '0;
      msrModel[msrNxmBit]             = nxmModel;
      msrModel[msrScratchWidth-1:0]   = scratchModel;
   endtask

   // One complete four-phase transfer
   task automatic transfer(input wordT addr, input wordT data, input logic ackExpected);
      int   waitCnt;
      logic acked;
      waitCnt = 0;
      acked   = 1'b0;
      @(negedge cpuClk);
      busAddr      = addr;
      busDataIn    = data;
      busReq       = 1'b1;
      expectReject = !ackExpected;
      if (ackExpected)
      begin
         while (!acked && waitCnt < ackLimit)
         begin
            @(negedge cpuClk);
            waitCnt++;
            acked = busAck;
         end
         if (!acked)
         begin
            errors++;
            $display("No acknowledge within %0d cycles for address word %h", ackLimit, addr);
         end
      end
      else
         repeat (rejectHold) @(negedge cpuClk);
      busReq  = 1'b0;  // Master releases
      waitCnt = 0;
      while (busAck && waitCnt < ackLimit)
      begin
         @(negedge cpuClk);
         waitCnt++;
      end
      if (busAck)
      begin
         errors++;
         $display("busAck still high long after busReq dropped");
      end
      @(negedge cpuClk);  // Decoder back in idle
      expectReject = 1'b0;
   endtask

   task automatic writeMem(input int a, input wordT d);
      refMem[a] = d;
      transfer(memWord(1'b0, 1'b0, 1'b1, a), d, 1'b1);
   endtask

   task automatic readMem(input int a);
      expData = refMem[a];
      chkMem  = 1'b1;
      transfer(memWord(1'b1, 1'b0, 1'b0, a), randWord(), 1'b1);
      chkMem  = 1'b0;
   endtask

   task automatic writeTestMem(input int a, input wordT d);
      expData = refMem[a];  // Write-test leaves memory alone
      chkMem  = 1'b1;
      transfer(memWord(1'b0, 1'b1, 1'b0, a), d, 1'b1);
      chkMem  = 1'b0;
   endtask

   task automatic readMsr();
      chkMsr = 1'b1;
      transfer(ioWord(1'b1, 1'b0, memDev, addrMsr), '0, 1'b1);
      chkMsr = 1'b0;
   endtask

   task automatic writeMsr(input wordT d);
      transfer(ioWord(1'b0, 1'b1, memDev, addrMsr), d, 1'b1);
      scratchModel = d[msrScratchWidth-1:0];
      if (d[msrNxmBit])
         nxmModel = 1'b0;  // Write one clears
      updateMsr();
   endtask

   // Out of range, no ack, NXM raised
   task automatic nxmAccess(input int a, input logic wr);
      transfer(memWord(!wr, 1'b0, wr, a), randWord(), 1'b0);
      nxmModel = 1'b1;
      updateMsr();
   endtask

   task automatic beginTest(input string name);
      testNum++;
      testName     = name;
      testErrStart = errors;
   endtask

   task automatic closeTest();
      if (errors == testErrStart)
         $display("Test %0d %s: ok", testNum, testName);
      else
      begin
         failedTests++;
         $display("Test %0d %s: %0d errors", testNum, testName, errors - testErrStart);
      end
   endtask

   ////////////////////
   // Stimulus

   initial
   begin
      wordT d;
      int   a;
      busReq       = 1'b0;
      busAddr      = '0;
      busDataIn    = '0;
      chkMem       = 1'b0;
      chkMsr       = 1'b0;
      expectReject = 1'b0;
      expData      = '0;
      nxmModel     = 1'b0;
      scratchModel = '0;
      updateMsr();
      @(negedge rst);
      @(negedge cpuClk);

      beginTest("reset state and MSR read");
      idleAfterReset: assert (busAck == 1'b0)
         else
         begin
            errors++;
            $display("FAILED busAck %h expected 0", busAck);
         end
      readMsr();
      closeTest();

      beginTest("random writes and reads");
      for (int i = 0; i < 32; i++)
      begin
         addrList[i] = $unsigned($random(seed)) % memWords;
         writeMem(addrList[i], randWord());
      end
      for (int i = 0; i < 32; i++)
         readMem(addrList[i]);
      closeTest();

      beginTest("write-test then read");
      writeTestMem(addrList[3], randWord());
      readMem(addrList[3]);
      closeTest();

      beginTest("MSR scratch write");
      d            = randWord();
      d[msrNxmBit] = 1'b1;  // Nothing pending, stays clear
      writeMsr(d);
      readMsr();
      closeTest();

      beginTest("nonexistent memory");
      a = memWords + ($unsigned($random(seed)) % ((1 << 20) - memWords));
      nxmAccess(a, 1'b0);
      readMsr();
      nxmAccess(memWords + addrList[0], 1'b1);  // Aliases a written word
      readMsr();
      d            = msrModel;
      d[msrNxmBit] = 1'b1;
      writeMsr(d);
      readMsr();
      readMem(addrList[0]);
      closeTest();

      beginTest("foreign IO requests");
      transfer(ioWord(1'b1, 1'b0, 4'd1, addrMsr), '0, 1'b0);
      transfer(ioWord(1'b0, 1'b1, 4'd0, addrMsr + 18'd2), randWord(), 1'b0);
      transfer(ioWord(1'b0, 1'b1, 4'd3, addrMsr), randWord(), 1'b0);
      readMsr();
      closeTest();

      $display("Tests run %0d, tests failed %0d, errors %0d", testNum, failedTests, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

/* verification/ssramModel.sv */
////////////////////
// Behavioral pipelined SRAM
// Decodes only the low address bits like a part of that size
// Read data appears latency edges after the command
////////////////////

`timescale 1ns/1ns
`default_nettype none

module ssramModel #(
   parameter int addrWidth = 20,
   parameter int words     = 65536,
   parameter int latency   = 2
) (
   input  logic                 clk,
   input  logic [addrWidth-1:0] addr,
   input  ks10MemPkg::wordT     dataIn,   // From controller
   output ks10MemPkg::wordT     dataOut,  // To controller
   input  logic                 weN,
   input  logic                 ceN,
   input  logic                 oe
);
   import ks10MemPkg::*;

   localparam int idxWidth = $clog2(words);

   wordT                memArray [words];
   wordT                pipe [latency];   // Read pipeline stages
   logic [idxWidth-1:0] idx;              // Upper address bits alias

   assign idx     = addr[idxWidth-1:0];
   assign dataOut = pipe[latency-1];

   initial
   begin
      for (int i = 0; i < latency; i++)
         pipe[i] = '0;
   end

   always @(posedge clk)
   begin
      if (!ceN && !weN && oe)
         memArray[idx] <= dataIn;
      // Stage 0 loads on a read command and clears otherwise
      pipe[0] <= (!ceN && weN) ? memArray[idx] : '0;
      for (int i = 1; i < latency; i++)
         pipe[i] <= pipe[i-1];
   end

endmodule

`default_nettype wire

/* verification/clockGen.sv */
////////////////////
// Testbench clock and reset
////////////////////

`timescale 1ns/1ns
`default_nettype none

module clockGen #(
   parameter int halfPeriod  = 2,  // 4 ns clock
   parameter int resetCycles = 4
) (
   output logic cpuClk,
   output logic rst
);

   initial
   begin
      cpuClk = 1'b0;
      forever #halfPeriod cpuClk = ~cpuClk;
   end

   initial
   begin
      rst = 1'b1;
      repeat (resetCycles) @(posedge cpuClk);
      rst <= 1'b0;  // Released on a rising edge
   end

endmodule

`default_nettype wire

/* logic/memCtrl.sv */
////////////////////
// KS10 memory controller top
// Bus decoder, status register and SRAM sequencer
////////////////////

`timescale 1ns/1ns
`default_nettype none

module memCtrl #(
   parameter int memWords       = 65536,  // Populated words
   parameter int ssramAddrWidth = 20,
   parameter int readLatency    = 2       // SRAM pipeline depth
) (
   input  logic                      cpuClk,
   input  logic                      rst,
   input  logic                      busReq,
   output logic                      busAck,
   input  ks10MemPkg::wordT          busAddr,
   input  ks10MemPkg::wordT          busDataIn,
   output ks10MemPkg::wordT          busDataOut,
   output logic [ssramAddrWidth-1:0] ssramAddr,
   output ks10MemPkg::wordT          ssramDataOut,
   input  ks10MemPkg::wordT          ssramDataIn,
   output logic                      ssramWeN,
   output logic                      ssramCeN,
   output logic                      ssramOe
);
   import ks10MemPkg::*;

   wordT regStat;    // MSR contents
   logic msrWrite;
   wordT msrWData;
   logic nxmSet;

   // Decoder to sequencer
   memReqIf #(.ssramAddrWidth(ssramAddrWidth)) memIf ();

   busDecode #(
      .memWords       (memWords),
      .ssramAddrWidth (ssramAddrWidth)
   ) decode_i (
      .cpuClk     (cpuClk),
      .rst        (rst),
      .busReq     (busReq),
      .busAck     (busAck),
      .busAddr    (busAddr),
      .busDataIn  (busDataIn),
      .busDataOut (busDataOut),
      .regStat    (regStat),
      .msrWrite   (msrWrite),
      .msrWData   (msrWData),
      .nxmSet     (nxmSet),
      .mem        (memIf.dec)
   );

   memStatus status_i (
      .cpuClk   (cpuClk),
      .rst      (rst),
      .msrWrite (msrWrite),
      .msrWData (msrWData),
      .nxmSet   (nxmSet),
      .regStat  (regStat)
   );

   ssramCtrl #(
      .ssramAddrWidth (ssramAddrWidth),
      .readLatency    (readLatency)
   ) sram_i (
      .cpuClk       (cpuClk),
      .rst          (rst),
      .mem          (memIf.mem),
      .ssramAddr    (ssramAddr),
      .ssramDataOut (ssramDataOut),
      .ssramDataIn  (ssramDataIn),
      .ssramWeN     (ssramWeN),
      .ssramCeN     (ssramCeN),
      .ssramOe      (ssramOe)
   );

endmodule

`default_nettype wire

/* logic/ssramCtrl.sv */
////////////////////
// SRAM access sequencer
// Drives CE/WE/OE and address, captures pipelined read data
////////////////////

`timescale 1ns/1ns
`default_nettype none

module ssramCtrl #(
   parameter int ssramAddrWidth = 20,
   parameter int readLatency    = 2
) (
   input  logic                      cpuClk,
   input  logic                      rst,
   memReqIf.mem                      mem,
   output logic [ssramAddrWidth-1:0] ssramAddr,
   output ks10MemPkg::wordT          ssramDataOut,
   input  ks10MemPkg::wordT          ssramDataIn,
   output logic                      ssramWeN,      // Active low write strobe
   output logic                      ssramCeN,      // Active low chip enable
   output logic                      ssramOe        // We drive ssramDataOut
);
   import ks10MemPkg::*;

   localparam int cntWidth = (readLatency > 1) ? $clog2(readLatency) : 1;
   localparam logic [cntWidth-1:0] lastCnt = cntWidth'(readLatency - 1);

   typedef enum logic [1:0] {stIdle, stIssue, stWait, stDone} stateT;

   stateT               state;
   logic [cntWidth-1:0] latCnt;   // Read pipeline position
   logic                capture;

   assign capture = (state == stWait) && (latCnt == lastCnt);

   ////////////////////
   // Sequencer FSM

   always_ff @(posedge cpuClk)
   begin
      if (rst)
      begin
         state      <= stIdle;
         latCnt     <= '0;
         ssramCeN   <= 1'b1;
         ssramWeN   <= 1'b1;
         ssramOe    <= 1'b0;
         mem.memAck <= 1'b0;
      end
      else
         case (state)
            stIdle:
               if (mem.memReq)
               begin
                  // Command goes out now, SRAM takes it next edge
                  ssramCeN <= 1'b0;
                  ssramWeN <= (mem.op != opWrite);
                  ssramOe  <= (mem.op == opWrite);
                  state    <= stIssue;
               end
            stIssue:
            begin
               ssramCeN <= 1'b1;  // Single cycle command
               ssramWeN <= 1'b1;
               ssramOe  <= 1'b0;
               latCnt   <= '0;
               if (mem.op == opWrite)
               begin
                  mem.memAck <= 1'b1;  // Write done after strobe
                  state      <= stDone;
               end
               else
                  state <= stWait;     // Read and write-test
            end
            stWait:
               if (latCnt == lastCnt)
               begin
                  mem.memAck <= 1'b1;
                  state      <= stDone;
               end
               else
                  latCnt <= latCnt + 1'b1;
            stDone:
               if (!mem.memReq)
               begin
                  mem.memAck <= 1'b0;
                  state      <= stIdle;
               end
            default:
               state <= stIdle;
         endcase
   end

   // Address, write data and read capture
   always_ff @(posedge cpuClk)
   begin
      if (state == stIdle && mem.memReq)
      begin
         ssramAddr    <= mem.addr;
         ssramDataOut <= mem.wData;
      end
      if (capture)
         mem.rData <= ssramDataIn;  // readLatency edges after command
   end

   // Strobe only while the decoder still holds a plain write, never a write-test
   weOnlyOnWrite: assert property (@(posedge cpuClk) disable iff (rst)
      !ssramWeN |-> mem.memReq && (mem.op == opWrite));

endmodule

`default_nettype wire

/* logic/memStatus.sv */
////////////////////
// Memory Status Register
// NXM flag, write-one-to-clear, plus a scratch field
////////////////////

`timescale 1ns/1ns
`default_nettype none

module memStatus (
   input  logic             cpuClk,
   input  logic             rst,
   input  logic             msrWrite,   // Write strobe
   input  ks10MemPkg::wordT msrWData,
   input  logic             nxmSet,     // From decoder NXM check
   output ks10MemPkg::wordT regStat
);
   import ks10MemPkg::*;

   logic                       nxmFlag;
   logic [msrScratchWidth-1:0] scratch;

   always_ff @(posedge cpuClk)
   begin
      if (rst)
      begin
         nxmFlag <= 1'b0;
         scratch <= '0;
      end
      else
      begin
         if (msrWrite)
            scratch <= msrWData[msrScratchWidth-1:0];
         // Set beats clear in the same cycle
         if (nxmSet)
            nxmFlag <= 1'b1;
         else if (msrWrite && msrWData[msrNxmBit])
            nxmFlag <= 1'b0;  // W1C
      end
   end

   // Unused bits read zero
   always_comb
   begin
      regStat                        = '0;
      regStat[msrNxmBit]             = nxmFlag;
      regStat[msrScratchWidth-1:0]   = scratch;
   end

endmodule

`default_nettype wire

/* logic/busDecode.sv */
////////////////////
// KS10 bus decoder
// Four-phase busReq/busAck handshake, flag decode, NXM check
////////////////////

`timescale 1ns/1ns
`default_nettype none

module busDecode #(
   parameter int memWords       = 65536,
   parameter int ssramAddrWidth = 20
) (
   input  logic             cpuClk,
   input  logic             rst,
   input  logic             busReq,      // Master request
   output logic             busAck,
   input  ks10MemPkg::wordT busAddr,     // Flags and address
   input  ks10MemPkg::wordT busDataIn,
   output ks10MemPkg::wordT busDataOut,
   input  ks10MemPkg::wordT regStat,     // Current MSR
   output logic             msrWrite,    // One-cycle strobe
   output ks10MemPkg::wordT msrWData,
   output logic             nxmSet,      // One-cycle strobe
   memReqIf.dec             mem
);
   import ks10MemPkg::*;

   typedef enum logic [1:0] {stIdle, stMemWait, stAck, stReject} stateT;

   stateT                      state;
   logic                       busRead;
   logic                       busWrTest;
   logic                       busWrite;
   logic                       busPhys;
   logic                       busIo;
   logic [busDevMsb:busDevLsb] busDev;
   logic [busIoAddrMsb:0]      busIoAddr;
   logic [busMemAddrMsb:0]     busMemAddr;
   logic                       isMsr;
   logic                       inRange;
   memOpT                      reqOp;
   logic                       take;        // Request accepted this edge

   ////////////////////
   // Address word decode

   assign busRead    = busAddr[busReadBit];
   assign busWrTest  = busAddr[busWrTestBit];
   assign busWrite   = busAddr[busWriteBit];
   assign busPhys    = busAddr[busPhysBit];
   assign busIo      = busAddr[busIoBit];
   assign busDev     = busAddr[busDevMsb:busDevLsb];
   assign busIoAddr  = busAddr[busIoAddrMsb:0];
   assign busMemAddr = busAddr[busMemAddrMsb:0];

   // Only device 0, register 100000 belongs to us on the IO side
   assign isMsr   = busIo && busPhys && (busDev == memDev) && (busIoAddr == addrMsr);
   assign inRange = 32'(busMemAddr) < memWords;  // Populated words only
   assign take    = (state == stIdle) && busReq;

   always_comb
   begin
      reqOp = opNone;
      if (busIo)
      begin
         if (isMsr && busRead)
            reqOp = opMsrRead;
         else if (isMsr && busWrite)
            reqOp = opMsrWrite;
      end
      else if (busWrTest)
         reqOp = opWrTest;               // Test wins over plain read
      else if (busRead)
         reqOp = opRead;
      else if (busWrite)
         reqOp = opWrite;
   end

   ////////////////////
   // Handshake FSM

   always_ff @(posedge cpuClk)
   begin
      if (rst)
      begin
         state      <= stIdle;
         busAck     <= 1'b0;
         mem.memReq <= 1'b0;
         msrWrite   <= 1'b0;
         nxmSet     <= 1'b0;
      end
      else
      begin
         msrWrite <= 1'b0;  // Strobes default low
         nxmSet   <= 1'b0;
         case (state)
            stIdle:
               if (busReq)
               begin
                  case (reqOp)
                     opMsrRead, opMsrWrite:
                     begin
                        // MSR served locally, ack next edge
                        busAck   <= 1'b1;
                        msrWrite <= (reqOp == opMsrWrite);
                        state    <= stAck;
                     end
                     opRead, opWrite, opWrTest:
                        if (inRange)
                        begin
                           mem.memReq <= 1'b1;
                           state      <= stMemWait;
                        end
                        else
                        begin
                           nxmSet <= 1'b1;  // Flag it, no ack
                           state  <= stReject;
                        end
                     default:
                        state <= stReject;  // Someone else's IO
                  endcase
               end
            stMemWait:
               if (mem.memAck)
               begin
                  mem.memReq <= 1'b0;
                  busAck     <= 1'b1;
                  state      <= stAck;
               end
            stAck:
               if (!busReq)
               begin
                  busAck <= 1'b0;  // Master released
                  state  <= stIdle;
               end
            stReject:
               if (!busReq)
                  state <= stIdle;  // Master timed out
            default:
               state <= stIdle;
         endcase
      end
   end

   // Request payload, latched at classification
   always_ff @(posedge cpuClk)
   begin
      if (take)
      begin
         busDataOut <= regStat;     // MSR value as seen now
         msrWData   <= busDataIn;
         mem.op     <= reqOp;
         mem.addr   <= busMemAddr[ssramAddrWidth-1:0];
         mem.wData  <= busDataIn;
      end
      else if (state == stMemWait && mem.memAck)
         busDataOut <= mem.rData;   // Memory result
   end

   // No ack without a request seen the cycle before
   ackFollowsReq: assert property (@(posedge cpuClk) disable iff (rst)
      busAck |-> $past(busReq));

endmodule

`default_nettype wire

/* logic/memReqIf.sv */
////////////////////
// Memory request channel
// Decoder to SRAM sequencer, with ack and read data back
////////////////////

`timescale 1ns/1ns
`default_nettype none

interface memReqIf #(
   parameter int ssramAddrWidth = 20
);
   import ks10MemPkg::*;

   logic                      memReq;  // Held until memAck
   memOpT                     op;      // Stable with memReq
   logic [ssramAddrWidth-1:0] addr;
   wordT                      wData;
   logic                      memAck;  // Drops a cycle after memReq
   wordT                      rData;   // Valid with memAck on reads

   // Decoder side
   modport dec (output memReq, output op, output addr, output wData,
                input  memAck, input  rData);

   // Sequencer side
   modport mem (input  memReq, input  op, input  addr, input  wData,
                output memAck, output rData);

endinterface

`default_nettype wire

/* logic/ks10MemPkg.sv */
////////////////////
// KS10 memory controller shared types
// Word type, bus address flags, MSR layout, memory opcodes
////////////////////

`default_nettype none

package ks10MemPkg;

   // One KS10 word, bit 35 is the leftmost flag
   typedef logic [35:0] wordT;

   ////////////////////
   // Bus address word flags

   localparam int busReadBit   = 35;  // Read cycle
   localparam int busWrTestBit = 34;  // Write-test cycle
   localparam int busWriteBit  = 33;  // Write cycle
   localparam int busPhysBit   = 32;  // Physical reference
   localparam int busIoBit     = 31;  // IO space, not memory

   // IO device number field
   localparam int busDevLsb = 18;
   localparam int busDevMsb = 21;

   localparam int busIoAddrMsb  = 17;  // IO register address, bits 17..0
   localparam int busMemAddrMsb = 19;  // Memory word address, bits 19..0

   ////////////////////
   // Device and status register

   localparam logic [3:0]  memDev  = 4'd0;       // Controller answers as device 0
   localparam logic [17:0] addrMsr = 18'o100000; // MSR IO address

   // MSR fields
   localparam int msrNxmBit       = 30;  // Nonexistent memory flag
   localparam int msrScratchWidth = 16;  // Read/write bits at the bottom

   ////////////////////
   // Decoded opcodes

   typedef enum logic [2:0]
   {
      opNone,      // Not ours
      opRead,      // Memory read
      opWrite,     // Memory write
      opWrTest,    // Write-test, acked read
      opMsrRead,   // Status register read
      opMsrWrite   // Status register write
   } memOpT;

endpackage

`default_nettype wire
